// File: Makefile
# Verilator build, run and lint for the shared-memory subsystem

VERILATOR ?= verilator
TOP       ?= mem_arb_tb
RTL_TOP   ?= mem_subsys_top
FILELIST  ?= mem_arb_sys.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter rtl/%,$(SRCS))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) $(LINTFLAGS) --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: mem_arb_sys.f
rtl/mem_arb_pkg.sv
rtl/stream_arb.sv
rtl/stream_switch.sv
rtl/mem_arb.sv
rtl/mem_bank.sv
rtl/mem_subsys_top.sv
verif/tb_clk_gen.sv
verif/mem_arb_tb.sv

// File: rtl/mem_arb.sv
// Requester to memory port arbiter
// Groups NUM_INPUTS requesters onto NUM_OUTPUTS memory ports, one
// round-robin arbiter per port. The winner's local index is inserted into
// the memory tag at TAG_SEL_IDX and taken out again on the response path
// to steer the response back to its requester.

`timescale 1ns/1ps
`default_nettype none

module mem_arb #(
    parameter int NUM_INPUTS  = 4,
    parameter int NUM_OUTPUTS = 1,
    parameter int TAG_SEL_IDX = 0,
    parameter int REQ_OUT_BUF = 1,
    parameter int RSP_OUT_BUF = 1
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic [NUM_INPUTS-1:0]  core_req_valid,
    input  mem_arb_pkg::core_req_t core_req [NUM_INPUTS],
    output logic [NUM_INPUTS-1:0]  core_req_ready,

    output logic [NUM_INPUTS-1:0]  core_rsp_valid,
    output mem_arb_pkg::core_rsp_t core_rsp [NUM_INPUTS],
    input  logic [NUM_INPUTS-1:0]  core_rsp_ready,

    output logic [NUM_OUTPUTS-1:0] mem_req_valid,
    output mem_arb_pkg::mem_req_t  mem_req [NUM_OUTPUTS],
    input  logic [NUM_OUTPUTS-1:0] mem_req_ready,

    input  logic [NUM_OUTPUTS-1:0] mem_rsp_valid,
    input  mem_arb_pkg::mem_rsp_t  mem_rsp [NUM_OUTPUTS],
    output logic [NUM_OUTPUTS-1:0] mem_rsp_ready
);

    localparam int GROUP = NUM_INPUTS / NUM_OUTPUTS;
    localparam int SEL_W = (GROUP > 1) ? $clog2(GROUP) : 1;
    localparam int TW    = mem_arb_pkg::TAG_WIDTH;
    localparam int MTW   = mem_arb_pkg::MEM_TAG_WIDTH;
    localparam int SB    = mem_arb_pkg::MAX_SEL_BITS;

    // Tag bits below TAG_SEL_IDX stay in place, the rest move up by SB
    localparam logic [MTW-1:0] LO_MASK = (MTW'(1) << TAG_SEL_IDX) - MTW'(1);

    function automatic logic [MTW-1:0] insert_sel(input logic [TW-1:0] tag,
                                                  input logic [SEL_W-1:0] sel);
        logic [MTW-1:0] wide;
        wide = MTW'(tag);
        return ((wide & ~LO_MASK) << SB) | (MTW'(sel) << TAG_SEL_IDX) | (wide & LO_MASK);
    endfunction

    function automatic logic [TW-1:0] strip_sel(input logic [MTW-1:0] mtag);
        return TW'(((mtag >> SB) & ~LO_MASK) | (mtag & LO_MASK));
    endfunction

    for (genvar p = 0; p < NUM_OUTPUTS; p++) begin : g_port
        mem_arb_pkg::core_req_t grp_req [GROUP];
        mem_arb_pkg::core_rsp_t grp_rsp [GROUP];
        mem_arb_pkg::core_req_t arb_req;
        mem_arb_pkg::core_rsp_t sw_rsp;
        logic [SEL_W-1:0]       arb_sel;
        logic [SEL_W-1:0]       rsp_sel;

        for (genvar g = 0; g < GROUP; g++) begin : g_member
            assign grp_req[g]            = core_req[p*GROUP + g];
            assign core_rsp[p*GROUP + g] = grp_rsp[g];
        end

        stream_arb #(
            .NUM_REQS  (GROUP),
            .OUT_BUF   (REQ_OUT_BUF),
            .payload_t (mem_arb_pkg::core_req_t)
        ) req_arb (
            .clk       (clk),
            .rst       (rst),
            .valid_in  (core_req_valid[p*GROUP +: GROUP]),
            .data_in   (grp_req),
            .ready_in  (core_req_ready[p*GROUP +: GROUP]),
            .valid_out (mem_req_valid[p]),
            .data_out  (arb_req),
            .sel_out   (arb_sel),
            .ready_out (mem_req_ready[p])
        );

        always_comb begin
            mem_req[p].tag    = insert_sel(arb_req.tag, arb_sel);
            mem_req[p].addr   = arb_req.addr;
            mem_req[p].rw     = arb_req.rw;
            mem_req[p].byteen = arb_req.byteen;
            mem_req[p].data   = arb_req.data;
        end

        // Response path recovers the source index and the original tag
        assign rsp_sel     = mem_rsp[p].tag[TAG_SEL_IDX +: SEL_W];
        assign sw_rsp.tag  = strip_sel(mem_rsp[p].tag);
        assign sw_rsp.data = mem_rsp[p].data;

        stream_switch #(
            .NUM_OUTS  (GROUP),
            .OUT_BUF   (RSP_OUT_BUF),
            .payload_t (mem_arb_pkg::core_rsp_t)
        ) rsp_switch (
            .clk       (clk),
            .rst       (rst),
            .valid_in  (mem_rsp_valid[p]),
            .data_in   (sw_rsp),
            .sel_in    (rsp_sel),
            .ready_in  (mem_rsp_ready[p]),
            .valid_out (core_rsp_valid[p*GROUP +: GROUP]),
            .data_out  (grp_rsp),
            .ready_out (core_rsp_ready[p*GROUP +: GROUP])
        );
    end

endmodule

`default_nettype wire

// File: rtl/mem_arb_pkg.sv
// Shared-memory subsystem package
// Word geometry, tag widths and the request and response structs used on
// the requester side and on the memory side of the arbiter.

`default_nettype none

package mem_arb_pkg;

    // Word geometry
    localparam int DATA_SIZE  = 4;
    localparam int DATA_WIDTH = 8 * DATA_SIZE;
    localparam int ADDR_WIDTH = 8;

    // Requester tag and the source index field added on the memory side.
    // Two index bits allow up to 4 requesters per memory port
    localparam int TAG_WIDTH     = 4;
    localparam int MAX_SEL_BITS  = 2;
    localparam int MEM_TAG_WIDTH = TAG_WIDTH + MAX_SEL_BITS;

    // Requester-side request, rw set means write
    typedef struct packed {
        logic [TAG_WIDTH-1:0]  tag;
        logic [ADDR_WIDTH-1:0] addr;
        logic                  rw;
        logic [DATA_SIZE-1:0]  byteen;
        logic [DATA_WIDTH-1:0] data;
    } core_req_t;

    typedef struct packed {
        logic [TAG_WIDTH-1:0]  tag;
        logic [DATA_WIDTH-1:0] data;
    } core_rsp_t;

    // Memory-side request carries the widened tag
    typedef struct packed {
        logic [MEM_TAG_WIDTH-1:0] tag;
        logic [ADDR_WIDTH-1:0]    addr;
        logic                     rw;
        logic [DATA_SIZE-1:0]     byteen;
        logic [DATA_WIDTH-1:0]    data;
    } mem_req_t;

    typedef struct packed {
        logic [MEM_TAG_WIDTH-1:0] tag;
        logic [DATA_WIDTH-1:0]    data;
    } mem_rsp_t;

endpackage

`default_nettype wire

// File: rtl/mem_bank.sv
// On-chip memory bank
// Byte-enabled single-port RAM behind a valid/ready request stream.
// Writes land at the acceptance edge and give no response. Reads pass
// through a two-stage pipeline that carries the tag with the data and
// holds its contents while the response is back-pressured.

`timescale 1ns/1ps
`default_nettype none

module mem_bank #(
    parameter int MEM_DEPTH = 256
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  req_valid,
    input  mem_arb_pkg::mem_req_t req,
    output logic                  req_ready,

    output logic                  rsp_valid,
    output mem_arb_pkg::mem_rsp_t rsp,
    input  logic                  rsp_ready
);

    localparam int IDX_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;
    localparam int DS    = mem_arb_pkg::DATA_SIZE;

    logic [mem_arb_pkg::DATA_WIDTH-1:0] ram [MEM_DEPTH];

    logic [IDX_W-1:0]      idx;
    logic                  req_fire;
    logic                  s1_valid;
    logic                  s2_valid;
    logic                  s1_en;
    logic                  s2_en;
    mem_arb_pkg::mem_rsp_t s1_rsp;
    mem_arb_pkg::mem_rsp_t s2_rsp;

    assign idx = req.addr[IDX_W-1:0];

    // A stage moves when the stage after it is empty or moving too.
    // Requests only stop once both stages are full and the output is stalled
    assign s2_en     = !s2_valid || rsp_ready;
    assign s1_en     = !s1_valid || s2_en;
    assign req_ready = s1_en;
    assign req_fire  = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (req_fire && req.rw) begin
            for (int b = 0; b < DS; b++) begin
                if (req.byteen[b]) begin
                    ram[idx][8*b +: 8] <= req.data[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (s1_en) begin
                s1_valid <= req_fire && !req.rw;
            end
            if (s2_en) begin
                s2_valid <= s1_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire && !req.rw) begin
            s1_rsp.tag  <= req.tag;
            s1_rsp.data <= ram[idx];
        end
        if (s2_en && s1_valid) begin
            s2_rsp <= s1_rsp;
        end
    end

    assign rsp_valid = s2_valid;
    assign rsp       = s2_rsp;

endmodule

`default_nettype wire

// File: rtl/mem_subsys_top.sv
// Shared-memory subsystem top level
// Connects the requester ports through mem_arb to one memory bank per
// memory port.

`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top #(
    parameter int NUM_INPUTS  = 4,
    parameter int NUM_OUTPUTS = 1,
    parameter int TAG_SEL_IDX = 0,
    parameter int REQ_OUT_BUF = 1,
    parameter int RSP_OUT_BUF = 1,
    parameter int MEM_DEPTH   = 256
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic [NUM_INPUTS-1:0]  core_req_valid,
    input  mem_arb_pkg::core_req_t core_req [NUM_INPUTS],
    output logic [NUM_INPUTS-1:0]  core_req_ready,

    output logic [NUM_INPUTS-1:0]  core_rsp_valid,
    output mem_arb_pkg::core_rsp_t core_rsp [NUM_INPUTS],
    input  logic [NUM_INPUTS-1:0]  core_rsp_ready
);

    logic [NUM_OUTPUTS-1:0] mem_req_valid;
    mem_arb_pkg::mem_req_t  mem_req [NUM_OUTPUTS];
    logic [NUM_OUTPUTS-1:0] mem_req_ready;
    logic [NUM_OUTPUTS-1:0] mem_rsp_valid;
    mem_arb_pkg::mem_rsp_t  mem_rsp [NUM_OUTPUTS];
    logic [NUM_OUTPUTS-1:0] mem_rsp_ready;

    mem_arb #(
        .NUM_INPUTS  (NUM_INPUTS),
        .NUM_OUTPUTS (NUM_OUTPUTS),
        .TAG_SEL_IDX (TAG_SEL_IDX),
        .REQ_OUT_BUF (REQ_OUT_BUF),
        .RSP_OUT_BUF (RSP_OUT_BUF)
    ) arb0 (
        .clk            (clk),
        .rst            (rst),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .core_rsp_ready (core_rsp_ready),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp        (mem_rsp),
        .mem_rsp_ready  (mem_rsp_ready)
    );

    for (genvar p = 0; p < NUM_OUTPUTS; p++) begin : g_bank
        mem_bank #(
            .MEM_DEPTH (MEM_DEPTH)
        ) bank (
            .clk       (clk),
            .rst       (rst),
            .req_valid (mem_req_valid[p]),
            .req       (mem_req[p]),
            .req_ready (mem_req_ready[p]),
            .rsp_valid (mem_rsp_valid[p]),
            .rsp       (mem_rsp[p]),
            .rsp_ready (mem_rsp_ready[p])
        );
    end

endmodule

`default_nettype wire

// File: rtl/stream_arb.sv
// Round-robin N-to-1 arbiter for valid/ready streams
// Picks one valid input per cycle starting after the last winner and
// forwards its payload with the winning index. An optional one-entry
// register slice sits on the output.

`timescale 1ns/1ps
`default_nettype none

module stream_arb #(
    parameter int  NUM_REQS  = 4,
    parameter int  OUT_BUF   = 1,
    parameter type payload_t = logic [7:0],
    localparam int SEL_W     = (NUM_REQS > 1) ? $clog2(NUM_REQS) : 1
) (
    input  logic                clk,
    input  logic                rst,

    input  logic [NUM_REQS-1:0] valid_in,
    input  payload_t            data_in [NUM_REQS],
    output logic [NUM_REQS-1:0] ready_in,

    output logic                valid_out,
    output payload_t            data_out,
    output logic [SEL_W-1:0]    sel_out,
    input  logic                ready_out
);

    logic [SEL_W-1:0] rr_ptr;
    logic [SEL_W-1:0] grant_idx;
    logic             grant_valid;
    logic             accept;

    // Search the inputs in order, starting just after the last winner
    always_comb begin
        int unsigned cand;
        grant_valid = 1'b0;
        grant_idx   = rr_ptr;
        for (int off = 1; off <= NUM_REQS; off++) begin
            cand = (int'(rr_ptr) + off) % NUM_REQS;
            if (!grant_valid && valid_in[cand]) begin
                grant_valid = 1'b1;
                grant_idx   = SEL_W'(cand);
            end
        end
    end

    for (genvar i = 0; i < NUM_REQS; i++) begin : g_ready
        assign ready_in[i] = accept && grant_valid && (grant_idx == SEL_W'(i));
    end

    // Pointer only moves on an actual transfer, so an idle cycle keeps the order.
    // Starting at the last input lets input 0 win first
    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr <= SEL_W'(NUM_REQS - 1);
        end else if (accept && grant_valid) begin
            rr_ptr <= grant_idx;
        end
    end

    if (OUT_BUF != 0) begin : g_buf
        typedef struct packed {
            payload_t         data;
            logic [SEL_W-1:0] sel;
        } slot_t;

        logic  slot_valid;
        slot_t slot;

        // The slot can refill in the same cycle it drains
        assign accept = !slot_valid || ready_out;

        always_ff @(posedge clk) begin
            if (rst) begin
                slot_valid <= 1'b0;
            end else if (accept) begin
                slot_valid <= grant_valid;
            end
        end

        always_ff @(posedge clk) begin
            if (accept && grant_valid) begin
                slot.data <= data_in[grant_idx];
                slot.sel  <= grant_idx;
            end
        end

        assign valid_out = slot_valid;
        assign data_out  = slot.data;
        assign sel_out   = slot.sel;
    end else begin : g_comb
        assign accept    = ready_out;
        assign valid_out = grant_valid;
        assign data_out  = data_in[grant_idx];
        assign sel_out   = grant_idx;
    end

endmodule

`default_nettype wire

// File: rtl/stream_switch.sv
// 1-to-N router for valid/ready streams
// Each item goes to the output picked by sel_in. With the output slices
// enabled every output has its own one-entry register, so a stall on one
// output only blocks items headed for it.

`timescale 1ns/1ps
`default_nettype none

module stream_switch #(
    parameter int  NUM_OUTS  = 4,
    parameter int  OUT_BUF   = 1,
    parameter type payload_t = logic [7:0],
    localparam int SEL_W     = (NUM_OUTS > 1) ? $clog2(NUM_OUTS) : 1
) (
    input  logic                clk,
    input  logic                rst,

    input  logic                valid_in,
    input  payload_t            data_in,
    input  logic [SEL_W-1:0]    sel_in,
    output logic                ready_in,

    output logic [NUM_OUTS-1:0] valid_out,
    output payload_t            data_out [NUM_OUTS],
    input  logic [NUM_OUTS-1:0] ready_out
);

    logic [NUM_OUTS-1:0] dest_ready;
    logic                sel_ok;

    // An index past the last output is never accepted
    assign sel_ok   = (int'(sel_in) < NUM_OUTS);
    assign ready_in = sel_ok && dest_ready[sel_in];

    if (OUT_BUF != 0) begin : g_buf
        for (genvar j = 0; j < NUM_OUTS; j++) begin : g_out
            logic     slot_valid;
            payload_t slot_data;
            logic     load;

            assign dest_ready[j] = !slot_valid || ready_out[j];
            assign load          = valid_in && ready_in && (sel_in == SEL_W'(j));

            always_ff @(posedge clk) begin
                if (rst) begin
                    slot_valid <= 1'b0;
                end else if (dest_ready[j]) begin
                    slot_valid <= load;
                end
            end

            always_ff @(posedge clk) begin
                if (load) begin
                    slot_data <= data_in;
                end
            end

            assign valid_out[j] = slot_valid;
            assign data_out[j]  = slot_data;
        end
    end else begin : g_comb
        for (genvar j = 0; j < NUM_OUTS; j++) begin : g_out
            assign dest_ready[j] = ready_out[j];
            assign valid_out[j]  = valid_in && (sel_in == SEL_W'(j));
            assign data_out[j]   = data_in;
        end
    end

endmodule

`default_nettype wire

// File: verif/mem_arb_tb.sv
// Testbench for the shared-memory subsystem
// Walks a stimulus table through four requesters, predicts read data with a
// shadow memory and checks routing, per-requester order, read latency and
// round-robin grants, with random response back-pressure in the last phase.

`timescale 1ns/1ps
`default_nettype none

module mem_arb_tb;

    localparam int NUM_INPUTS   = 4;
    localparam int NUM_OUTPUTS  = 1;
    localparam int TAG_SEL_IDX  = 0;
    localparam int REQ_OUT_BUF  = 1;
    localparam int RSP_OUT_BUF  = 1;
    localparam int MEM_DEPTH    = 256;
    localparam int RD_LATENCY   = 4;
    localparam int TIMEOUT      = 500;
    localparam int AW           = mem_arb_pkg::ADDR_WIDTH;
    localparam int DW           = mem_arb_pkg::DATA_WIDTH;
    localparam int DS           = mem_arb_pkg::DATA_SIZE;
    localparam logic [31:0] SEED = 32'hbe492b85;

    // One operation of one requester, delay counts idle cycles before it
    typedef struct {
        int            phase;
        int            req;
        logic          rw;
        logic [AW-1:0] addr;
        logic [DS-1:0] byteen;
        logic [DW-1:0] data;
        int            delay;
    } row_t;

    logic                   clk;
    logic                   rst;
    logic [NUM_INPUTS-1:0]  core_req_valid;
    mem_arb_pkg::core_req_t core_req [NUM_INPUTS];
    logic [NUM_INPUTS-1:0]  core_req_ready;
    logic [NUM_INPUTS-1:0]  core_rsp_valid;
    mem_arb_pkg::core_rsp_t core_rsp [NUM_INPUTS];
    logic [NUM_INPUTS-1:0]  core_rsp_ready;

    row_t                   stim_rows [$];
    logic [DW-1:0]          shadow [MEM_DEPTH];
    mem_arb_pkg::core_rsp_t pending [NUM_INPUTS][$];
    logic [mem_arb_pkg::TAG_WIDTH-1:0] next_tag [NUM_INPUTS];
    logic [31:0]            lfsr;
    logic                   stall_en;
    int                     cur_phase;
    int                     cycle_count = 0;
    int                     last_grant = NUM_INPUTS - 1;
    int                     lat_start = -1;

    tb_clk_gen #(.PERIOD_NS(8), .RESET_CYCLES(10)) clk_gen0 (.clk(clk), .rst(rst));

    mem_subsys_top #(
        .NUM_INPUTS  (NUM_INPUTS),
        .NUM_OUTPUTS (NUM_OUTPUTS),
        .TAG_SEL_IDX (TAG_SEL_IDX),
        .REQ_OUT_BUF (REQ_OUT_BUF),
        .RSP_OUT_BUF (RSP_OUT_BUF),
        .MEM_DEPTH   (MEM_DEPTH)
    ) dut0 (
        .clk            (clk),
        .rst            (rst),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .core_rsp_ready (core_rsp_ready)
    );

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_rsp(input mem_arb_pkg::core_rsp_t got,
                             input mem_arb_pkg::core_rsp_t exp, input string name);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s got tag %h data %h expected tag %h data %h",
                                name, got.tag, got.data, exp.tag, exp.data));
        end
    endtask

    // Galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end else begin
            return s >> 1;
        end
    endfunction

    function automatic logic take_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr_step(lfsr);
        return b;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v = {v[30:0], take_bit()};
        end
        return v;
    endfunction

    function automatic logic [DW-1:0] fill_word(input logic [AW-1:0] a);
        return {a, ~a, a ^ 8'ha5, a + 8'h3c};
    endfunction

    function automatic void add_row(input int phase, input int req, input logic rw,
                                    input logic [AW-1:0] addr, input logic [DS-1:0] byteen,
                                    input logic [DW-1:0] data, input int delay);
        row_t row;
        row = '{phase, req, rw, addr, byteen, data, delay};
        stim_rows.push_back(row);
    endfunction

    function automatic int pending_count();
        int n;
        n = 0;
        for (int i = 0; i < NUM_INPUTS; i++) begin
            n += pending[i].size();
        end
        return n;
    endfunction

    task automatic build_table();
        logic          rw;
        logic [AW-1:0] addr;
        logic [DS-1:0] be;
        logic [DW-1:0] data;
        int            delay;
        // Phase 1 is a lone write and read-back on requester 0
        add_row(1, 0, 1'b1, 8'h20, 4'hf, 32'hc0de1234, 0);
        add_row(1, 0, 1'b0, 8'h20, 4'h0, 32'h0, 2);
        // Phase 2 fills words 0 to 15, then merges partial writes into 4 to 7
        for (int a = 0; a < 16; a++) begin
            add_row(2, a % NUM_INPUTS, 1'b1, 8'(a), 4'hf, fill_word(8'(a)), 0);
        end
        add_row(2, 0, 1'b1, 8'h04, 4'b0001, 32'h111111aa, 1);
        add_row(2, 1, 1'b1, 8'h05, 4'b0110, 32'h22bbcc22, 0);
        add_row(2, 2, 1'b1, 8'h06, 4'b1010, 32'hdd33ee33, 2);
        add_row(2, 3, 1'b1, 8'h07, 4'b1001, 32'hff444499, 0);
        add_row(2, 0, 1'b1, 8'h04, 4'b1100, 32'h55667777, 0);
        for (int r = 0; r < NUM_INPUTS; r++) begin
            add_row(2, r, 1'b0, 8'(4 + r), 4'h0, 32'h0, 1);
        end
        // Phase 3 has every requester reading overlapping words at once
        for (int r = 0; r < NUM_INPUTS; r++) begin
            for (int k = 0; k < 4; k++) begin
                add_row(3, r, 1'b0, 8'(r + k), 4'h0, 32'h0, 0);
            end
        end
        // Phase 4 keeps all requests valid back to back
        for (int k = 0; k < 6; k++) begin
            for (int r = 0; r < NUM_INPUTS; r++) begin
                add_row(4, r, 1'b0, 8'(8 + k), 4'h0, 32'h0, 0);
            end
        end
        // Phase 5 is random traffic over words 0 to 7
        for (int n = 0; n < 32; n++) begin
            rw    = take_bit();
            addr  = 8'(take_bits(3));
            be    = 4'(take_bits(4));
            data  = take_bits(32);
            delay = int'(take_bits(2));
            add_row(5, n % NUM_INPUTS, rw, addr, be, data, delay);
        end
    endtask

    task automatic drive_rsp_ready();
        forever begin
            @(negedge clk);
            for (int i = 0; i < NUM_INPUTS; i++) begin
                core_rsp_ready[i] = stall_en ? take_bit() : 1'b1;
            end
        end
    endtask

    task automatic wait_accept(input int r);
        int waited;
        waited = 0;
        @(posedge clk);
        while (core_req_ready[r] !== 1'b1) begin
            waited++;
            if (waited > TIMEOUT) begin
                abort_run($sformatf("request on requester %0d was never accepted", r));
            end
            @(posedge clk);
        end
    endtask

    task automatic run_requester(input int r);
        row_t row;
        foreach (stim_rows[n]) begin
            row = stim_rows[n];
            if (row.phase == cur_phase && row.req == r) begin
                for (int d = 0; d < row.delay; d++) begin
                    core_req_valid[r] = 1'b0;
                    @(negedge clk);
                end
                core_req[r].tag    = next_tag[r];
                core_req[r].addr   = row.addr;
                core_req[r].rw     = row.rw;
                core_req[r].byteen = row.byteen;
                core_req[r].data   = row.data;
                core_req_valid[r]  = 1'b1;
                next_tag[r]        = next_tag[r] + 1'b1;
                wait_accept(r);
                @(negedge clk);
            end
        end
        core_req_valid[r] = 1'b0;
    endtask

    task automatic run_phase(input int p, input logic stall);
        int waited;
        cur_phase = p;
        stall_en  = stall;
        fork
            run_requester(0);
            run_requester(1);
            run_requester(2);
            run_requester(3);
        join
        waited = 0;
        while (pending_count() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                abort_run($sformatf("phase %0d ended with %0d responses missing",
                                    p, pending_count()));
            end
        end
    endtask

    // Predicts at the acceptance edge, since requests reach the single bank in that order
    always @(posedge clk) begin : monitor
        mem_arb_pkg::core_rsp_t exp;
        logic [AW-1:0]          a;
        int                     nxt;
        cycle_count++;
        if (rst === 1'b0) begin
            if (lat_start >= 0 && cycle_count > lat_start) begin
                check_bit(core_rsp_valid[0], cycle_count == lat_start + RD_LATENCY,
                          "core_rsp_valid[0]");
                if (cycle_count == lat_start + RD_LATENCY) begin
                    lat_start = -1;
                end
            end
            for (int i = 0; i < NUM_INPUTS; i++) begin
                if (core_req_valid[i] && core_req_ready[i]) begin
                    nxt = (last_grant + 1) % NUM_INPUTS;
                    if (cur_phase == 4) begin
                        check_bit(core_req_ready[nxt], 1'b1,
                                  $sformatf("core_req_ready[%0d]", nxt));
                    end
                    last_grant = i;
                    a = core_req[i].addr;
                    if (core_req[i].rw) begin
                        for (int b = 0; b < DS; b++) begin
                            if (core_req[i].byteen[b]) begin
                                shadow[a][8*b +: 8] = core_req[i].data[8*b +: 8];
                            end
                        end
                    end else begin
                        exp.tag  = core_req[i].tag;
                        exp.data = shadow[a];
                        pending[i].push_back(exp);
                        if (cur_phase == 1) begin
                            lat_start = cycle_count;
                        end
                    end
                end
            end
            for (int i = 0; i < NUM_INPUTS; i++) begin
                if (core_rsp_valid[i] && core_rsp_ready[i]) begin
                    if (pending[i].size() == 0) begin
                        abort_run($sformatf("requester %0d got a response it never asked for", i));
                    end else begin
                        check_rsp(core_rsp[i], pending[i].pop_front(),
                                  $sformatf("core_rsp[%0d]", i));
                    end
                end
            end
        end
    end

    initial begin : main
        int waited;
        core_req_valid = '0;
        core_rsp_ready = '1;
        stall_en       = 1'b0;
        cur_phase      = 0;
        lfsr           = SEED;
        for (int i = 0; i < NUM_INPUTS; i++) begin
            core_req[i] = '0;
            next_tag[i] = '0;
        end
        build_table();
        fork
            drive_rsp_ready();
        join_none
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                abort_run("reset was never released");
            end
        end while (rst !== 1'b0);
        for (int i = 0; i < NUM_INPUTS; i++) begin
            check_bit(core_rsp_valid[i], 1'b0, $sformatf("core_rsp_valid[%0d]", i));
        end
        run_phase(1, 1'b0);
        run_phase(2, 1'b0);
        run_phase(3, 1'b0);
        run_phase(4, 1'b0);
        run_phase(5, 1'b1);
        stall_en = 1'b0;
        // Nothing may show up once every read has been answered
        for (int c = 0; c < 10; c++) begin
            @(negedge clk);
            for (int i = 0; i < NUM_INPUTS; i++) begin
                check_bit(core_rsp_valid[i], 1'b0, $sformatf("core_rsp_valid[%0d]", i));
            end
        end
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/tb_clk_gen.sv
// Testbench clock and reset generator
// Free-running clock with a synchronous active-high reset held for a
// fixed number of cycles after time zero.

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire
